// ==== filelist.f ====
+incdir+src
src/rxcap_bus_pkg.sv
src/rxcap_frame_pkg.sv
src/frame_wr_if.sv
src/frame_receiver.sv
src/frame_buffer.sv
src/host_regs.sv
src/rxcap_top.sv
tests/rxcap_properties.sv
tests/rxcap_tb.sv

// ==== tests/rxcap_tb.sv ====
`timescale 1ns/1ps
`include "rxcap_defs.svh"

module rxcap_tb
  import rxcap_bus_pkg::*, rxcap_frame_pkg::*;
();

  localparam int NROWS = 6;
  localparam bus_addr_t RX_BASE = 16'h8000;

  // arm mode 0 none, 1 before the frame, 2 during a frame that is skipped
  int row_arm [NROWS] = '{1, 1, 0, 2, 1, 0};
  int row_len [NROWS] = '{40, 17, 20, 24, 9, 6};
  int row_gap [NROWS] = '{4, 6, 5, 8, 3, 4};
  bus_addr_t unmapped [6] = '{16'h800a, 16'h800c, 16'h800e, 16'h000a, 16'h2000, 16'he004};

  logic        clk_125 = 1'b0;
  logic        core_rst_n = 1'b0;
  logic        rx_dv_i = 1'b0;
  frame_byte_t rx_data_i = '0;
  logic        cyc_i = 1'b0;
  logic        stb_i = 1'b0;
  logic        we_i = 1'b0;
  bus_addr_t   adr_i = '0;
  bus_data_t   dat_i = '0;
  bus_sel_t    sel_i = '0;
  bus_data_t   dat_o;
  logic        ack_o;
  logic        irq_o;

  int          cycle = 0;
  int          limit = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          failed = 0;
  logic [15:0] lfsr = 16'd36;
  bus_data_t   model [64];
  int          frame_start = 0;
  int          last_start = 0;
  timestamp_t  last_ts = '0;
  frame_len_t  last_len = '0;
  logic        have_ts = 1'b0;

  rxcap_top i_rxcap_top (.*);

  bind rxcap_top rxcap_properties i_props (
    .clk_125    (clk_125),
    .core_rst_n (core_rst_n),
    .ack_o      (ack_o),
    .irq_o      (irq_o),
    .frame_done (frame_done),
    .wr_en      (wr_if.wr_en),
    .state      (i_frame_receiver.state)
  );

  always #4 clk_125 = ~clk_125;

  always @(posedge clk_125) begin
    cycle <= cycle + 1;
    if (cycle > limit) begin
      $display("timeout after %0d cycles, the run did not finish", cycle);
      $display("Done: errors found");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic frame_byte_t next_byte();
    frame_byte_t b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b = {b[6:0], lfsr[0]};
    end
    return b;
  endfunction

  task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_len(input string name, input frame_len_t got, input frame_len_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_ts(input string name, input timestamp_t got, input timestamp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic bus_cycle(input logic we, input bus_addr_t addr, input bus_data_t wdata,
                           output bus_data_t rdata);
    int waited;
    int lat;
    waited = 0;
    rdata = '0;
    // buffer reads wait longer than register accesses
    if (!we && addr[15:13] == 3'(`RXCAP_REGION_RX) && addr[12:1] >= `RXCAP_BUF_BASE) begin
      lat = `RXCAP_BUF_RD_LAT;
    end else begin
      lat = 1;
    end
    @(posedge clk_125);
    cyc_i <= 1'b1;
    stb_i <= 1'b1;
    we_i  <= we;
    adr_i <= addr;
    dat_i <= wdata;
    sel_i <= 2'b11;
    do begin
      @(negedge clk_125);
      waited++;
    end while (!ack_o && waited < 16);
    checks++;
    if (ack_o) begin
      rdata = dat_o;
      if (waited != lat + 1) begin
        errors++;
        $display("bus access to address %h was acknowledged after %0d cycles instead of %0d",
                 addr, waited - 1, lat);
      end
    end else begin
      errors++;
      $display("bus access to address %h was never acknowledged", addr);
    end
    @(posedge clk_125);
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    we_i  <= 1'b0;
  endtask

  task automatic send_frame(input int len, input logic capture);
    frame_byte_t b;
    for (int i = 0; i < len; i++) begin
      b = next_byte();
      @(posedge clk_125);
      rx_dv_i   <= 1'b1;
      rx_data_i <= b;
      if (capture && i == 0) begin
        frame_start = cycle;
      end
      // even bytes low, odd bytes high
      if (capture && i % 2 == 0) begin
        model[i / 2][7:0] = b;
      end else if (capture) begin
        model[i / 2][15:8] = b;
      end
    end
    @(posedge clk_125);
    rx_dv_i <= 1'b0;
  endtask

  task automatic check_slot(input int len, input logic captured);
    bus_data_t  rd;
    timestamp_t ts;
    @(negedge clk_125);
    checks++;
    if (irq_o !== captured) begin
      errors++;
      $display("Error irq_o: got %h, expected %h", irq_o, captured);
    end
    bus_cycle(1'b0, 16'h0000, '0, rd);
    check_data("dat_o status", rd, bus_data_t'(captured));
    if (captured) begin
      last_len = frame_len_t'(len);
    end
    bus_cycle(1'b0, RX_BASE + 16'h0008, '0, rd);
    check_len("frame_len", frame_len_t'(rd), last_len);
    for (int w = 0; w < 4; w++) begin
      bus_cycle(1'b0, RX_BASE + bus_addr_t'(2 * w), '0, rd);
      ts[16*w +: 16] = rd;
    end
    if (!captured) begin
      check_ts("frame_ts", ts, last_ts);
    end else if (have_ts) begin
      check_ts("frame_ts", ts, last_ts + timestamp_t'(frame_start - last_start));
    end
    if (captured) begin
      last_ts    = ts;
      last_start = frame_start;
      have_ts    = 1'b1;
    end
    for (int w = 0; w < (len + 1) / 2; w++) begin
      bus_cycle(1'b0, RX_BASE + bus_addr_t'(2 * (`RXCAP_BUF_BASE + w)), '0, rd);
      check_data($sformatf("dat_o buffer word %0d", w), rd, model[w]);
    end
  endtask

  task automatic report(input string name, input int err_start);
    tests++;
    if (errors == err_start) begin
      $display("test %s: pass", name);
    end else begin
      failed++;
      $display("test %s: fail, %0d errors", name, errors - err_start);
    end
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    bus_data_t rd;
    bus_data_t wval [4];
    int        wcyc [4];
    int        err_start;
    int        waited;
    limit = 400;
    for (int r = 0; r < NROWS; r++) begin
      limit += row_len[r] * (row_arm[r] == 2 ? 2 : 1) + row_gap[r] + 300;
    end
    repeat (10) @(posedge clk_125);
    core_rst_n <= 1'b1;

    err_start = errors;
    wval = '{16'h0100, 16'ha5a5, 16'h3c3c, 16'h0001};
    for (int w = 0; w < 4; w++) begin
      bus_cycle(1'b1, bus_addr_t'(2 * (w + 1)), wval[w], rd);
      wcyc[w] = cycle;
    end
    for (int w = 0; w < 4; w++) begin
      bus_cycle(1'b0, bus_addr_t'(2 * (w + 1)), '0, rd);
      checks++;
      // counter keeps running after the write
      if (rd < wval[w] || int'(rd) > int'(wval[w]) + cycle - wcyc[w]) begin
        errors++;
        $display("Error dat_o counter word %0d: got %h, expected %h to %h", w, rd,
                 wval[w], wval[w] + bus_data_t'(cycle - wcyc[w]));
      end
    end
    report("counter write and read", err_start);

    for (int r = 0; r < NROWS; r++) begin
      err_start = errors;
      bus_cycle(1'b1, 16'h0000, (row_arm[r] == 1) ? 16'h0002 : 16'h0000, rd);
      if (row_arm[r] == 2) begin
        fork
          send_frame(row_len[r], 1'b0);
          begin
            repeat (4) @(posedge clk_125);
            bus_cycle(1'b1, 16'h0000, 16'h0002, rd);
          end
        join
      end
      repeat (row_gap[r]) @(posedge clk_125);
      send_frame(row_len[r], row_arm[r] != 0);
      waited = 0;
      while (irq_o !== 1'b1 && waited < 20) begin
        @(negedge clk_125);
        waited++;
      end
      check_slot(row_len[r], row_arm[r] != 0);
      report($sformatf("row %0d arm %0d len %0d", r, row_arm[r], row_len[r]), err_start);
    end

    err_start = errors;
    foreach (unmapped[i]) begin
      bus_cycle(1'b0, unmapped[i], '0, rd);
      check_data($sformatf("dat_o at %h", unmapped[i]), rd, '0);
    end
    report("unmapped reads", err_start);

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests, failed, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== tests/rxcap_properties.sv ====
`timescale 1ns/1ps

module rxcap_properties
  import rxcap_frame_pkg::*;
(
  input logic      clk_125,
  input logic      core_rst_n,
  input logic      ack_o,
  input logic      irq_o,
  input logic      frame_done,
  input logic      wr_en,
  input rx_state_e state
);

  // ack is a single-cycle pulse
  ack_single: assert property (
    @(posedge clk_125) disable iff (!core_rst_n) ack_o |=> !ack_o
  ) else $error("ack_o high on two consecutive cycles");

  wr_in_capture: assert property (
    @(posedge clk_125) disable iff (!core_rst_n) wr_en |-> state == CAPTURE
  ) else $error("buffer write outside CAPTURE");

  // irq only follows a finished frame
  irq_after_done: assert property (
    @(posedge clk_125) disable iff (!core_rst_n) $rose(irq_o) |-> $past(frame_done)
  ) else $error("irq_o rose without frame_done");

endmodule

// ==== src/rxcap_top.sv ====
`timescale 1ns/1ps

module rxcap_top
  import rxcap_bus_pkg::*, rxcap_frame_pkg::*;
(
  input  logic        clk_125,
  input  logic        core_rst_n,
  input  logic        rx_dv_i,
  input  frame_byte_t rx_data_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  bus_addr_t   adr_i,
  input  bus_data_t   dat_i,
  input  bus_sel_t    sel_i,
  output bus_data_t   dat_o,
  output logic        ack_o,
  output logic        irq_o
);

  logic       slot_credit;
  logic       frame_done;
  frame_len_t frame_len;
  timestamp_t frame_ts;
  timestamp_t global_count;
  buf_addr_t  buf_rd_addr;
  bus_data_t  buf_rd_data;

  frame_wr_if wr_if ();

  // receive stage
  frame_receiver i_frame_receiver (
    .clk_125        (clk_125),
    .core_rst_n     (core_rst_n),
    .rx_dv_i        (rx_dv_i),
    .rx_data_i      (rx_data_i),
    .slot_credit_i  (slot_credit),
    .global_count_i (global_count),
    .wr             (wr_if.source),
    .frame_done_o   (frame_done),
    .frame_len_o    (frame_len),
    .frame_ts_o     (frame_ts)
  );

  frame_buffer i_frame_buffer (
    .clk_125   (clk_125),
    .wr        (wr_if.sink),
    .rd_addr_i (buf_rd_addr),
    .rd_data_o (buf_rd_data)
  );

  // host side
  host_regs i_host_regs (
    .clk_125        (clk_125),
    .core_rst_n     (core_rst_n),
    .cyc_i          (cyc_i),
    .stb_i          (stb_i),
    .we_i           (we_i),
    .adr_i          (adr_i),
    .dat_i          (dat_i),
    .sel_i          (sel_i),
    .dat_o          (dat_o),
    .ack_o          (ack_o),
    .frame_done_i   (frame_done),
    .frame_len_i    (frame_len),
    .frame_ts_i     (frame_ts),
    .slot_credit_o  (slot_credit),
    .global_count_o (global_count),
    .buf_rd_addr_o  (buf_rd_addr),
    .buf_rd_data_i  (buf_rd_data),
    .irq_o          (irq_o)
  );

endmodule

// ==== src/host_regs.sv ====
`timescale 1ns/1ps
`include "rxcap_defs.svh"

module host_regs
  import rxcap_bus_pkg::*, rxcap_frame_pkg::*;
(
  input  logic       clk_125,
  input  logic       core_rst_n,
  input  logic       cyc_i,
  input  logic       stb_i,
  input  logic       we_i,
  input  bus_addr_t  adr_i,
  input  bus_data_t  dat_i,
  input  bus_sel_t   sel_i,
  output bus_data_t  dat_o,
  output logic       ack_o,
  input  logic       frame_done_i,
  input  frame_len_t frame_len_i,
  input  timestamp_t frame_ts_i,
  output logic       slot_credit_o,
  output timestamp_t global_count_o,
  output buf_addr_t  buf_rd_addr_o,
  input  bus_data_t  buf_rd_data_i,
  output logic       irq_o
);

  logic [2:0] region;
  buf_addr_t  word;
  logic       bus_req;
  logic       in_global;
  logic       in_rx;
  logic       buf_rd;
  logic       cnt_wr;
  logic       status_wr;
  logic [1:0] cnt_idx;
  logic [1:0] rd_wait;
  logic       frame_ready;
  bus_data_t  reg_rdata;
  timestamp_t cnt_next;

  assign region    = adr_i[15:13];
  assign word      = adr_i[12:1];
  assign bus_req   = cyc_i && stb_i && !ack_o;
  assign in_global = (region == 3'(`RXCAP_REGION_GLOBAL));
  assign in_rx     = (region == 3'(`RXCAP_REGION_RX));
  assign buf_rd    = in_rx && !we_i && (word >= buf_addr_t'(`RXCAP_BUF_BASE));
  assign cnt_wr    = bus_req && we_i && in_global && (word inside {[1:4]});
  assign status_wr = bus_req && we_i && in_global && (word == '0) && sel_i[0];
  // counter words 1..4 hold bits 15..0 up to 63..48
  assign cnt_idx   = word[1:0] - 2'd1;
  assign irq_o     = frame_ready;

  // free-running counter with byte-lane overwrite
  always_comb begin
    cnt_next = global_count_o + 1'b1;
    if (cnt_wr) begin
      for (int l = 0; l < 2; l++) begin
        if (sel_i[l]) begin
          cnt_next[16*cnt_idx + 8*l +: 8] = dat_i[8*l +: 8];
        end
      end
    end
  end

  // register read mux
  always_comb begin
    reg_rdata = '0;
    if (in_global) begin
      if (word == '0) begin
        reg_rdata = {14'b0, slot_credit_o, frame_ready};
      end else if (word inside {[1:4]}) begin
        reg_rdata = global_count_o[16*cnt_idx +: 16];
      end
    end else if (in_rx) begin
      if (word < 4) begin
        reg_rdata = frame_ts_i[16*word[1:0] +: 16];
      end else if (word == 4) begin
        reg_rdata = bus_data_t'(frame_len_i);
      end
    end
  end

  // ------------------------------------------------------------
  // bus handshake, slot status and counter
  // ------------------------------------------------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      ack_o          <= 1'b0;
      dat_o          <= '0;
      rd_wait        <= '0;
      frame_ready    <= 1'b0;
      slot_credit_o  <= 1'b0;
      global_count_o <= '0;
    end else begin
      ack_o          <= 1'b0;
      global_count_o <= cnt_next;
      if (frame_done_i) begin
        frame_ready   <= 1'b1;
        slot_credit_o <= 1'b0;
      end
      if (status_wr) begin
        // bit 1 arms the slot, bit 0 written low clears ready
        if (dat_i[1]) begin
          slot_credit_o <= 1'b1;
          frame_ready   <= 1'b0;
        end else begin
          frame_ready <= frame_ready & dat_i[0];
        end
      end
      if (bus_req && buf_rd) begin
        if (rd_wait == 2'(`RXCAP_BUF_RD_LAT - 1)) begin
          ack_o   <= 1'b1;
          dat_o   <= buf_rd_data_i;
          rd_wait <= '0;
        end else begin
          rd_wait <= rd_wait + 2'd1;
        end
      end else if (bus_req) begin
        ack_o   <= 1'b1;
        dat_o   <= reg_rdata;
        rd_wait <= '0;
      end else begin
        rd_wait <= '0;
      end
    end
  end

  // address into the buffer read port
  always_ff @(posedge clk_125) begin
    buf_rd_addr_o <= word;
  end

endmodule

// ==== src/frame_buffer.sv ====
`timescale 1ns/1ps
`include "rxcap_defs.svh"

module frame_buffer
  import rxcap_bus_pkg::*, rxcap_frame_pkg::*;
(
  input  logic      clk_125,
  frame_wr_if.sink  wr,
  input  buf_addr_t rd_addr_i,
  output bus_data_t rd_data_o
);

  localparam int DEPTH = 1 << `RXCAP_BUF_AW;
  localparam int LANES = `RXCAP_DATA_W / 8;

  bus_data_t mem [DEPTH];

  // write port, receiver side
  always_ff @(posedge clk_125) begin
    if (wr.wr_en) begin
      for (int l = 0; l < LANES; l++) begin
        if (wr.byte_en[l]) begin
          mem[wr.addr][8*l +: 8] <= wr.data[8*l +: 8];
        end
      end
    end
  end

  // read port, host side, one cycle latency
  always_ff @(posedge clk_125) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

// ==== src/frame_receiver.sv ====
`timescale 1ns/1ps
`include "rxcap_defs.svh"

module frame_receiver
  import rxcap_frame_pkg::*;
(
  input  logic        clk_125,
  input  logic        core_rst_n,
  input  logic        rx_dv_i,
  input  frame_byte_t rx_data_i,
  input  logic        slot_credit_i,
  input  timestamp_t  global_count_i,
  frame_wr_if.source  wr,
  output logic        frame_done_o,
  output frame_len_t  frame_len_o,
  output timestamp_t  frame_ts_o
);

  rx_state_e  state;
  frame_len_t byte_cnt;
  timestamp_t ts_cap;
  logic       done_pend;
  logic       take_byte;

  assign take_byte = (state == CAPTURE) && rx_dv_i;

  // ------------------------------------------------------------
  // FSM, byte count and frame report
  // ------------------------------------------------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      state        <= WAIT_CREDIT;
      byte_cnt     <= '0;
      done_pend    <= 1'b0;
      frame_done_o <= 1'b0;
      frame_len_o  <= '0;
      frame_ts_o   <= '0;
      wr.wr_en     <= 1'b0;
    end else begin
      wr.wr_en     <= take_byte;
      done_pend    <= 1'b0;
      frame_done_o <= done_pend;
      if (done_pend) begin
        frame_len_o <= byte_cnt;
        frame_ts_o  <= ts_cap;
      end
      case (state)
        WAIT_CREDIT: begin
          // the old credit is still visible until the host has seen done
          if (slot_credit_i && !done_pend && !frame_done_o) begin
            state <= WAIT_GAP;
          end
        end
        WAIT_GAP: begin
          // skip whatever frame is already on the wire
          if (slot_credit_i && !rx_dv_i) begin
            state    <= CAPTURE;
            byte_cnt <= '0;
          end
        end
        CAPTURE: begin
          if (rx_dv_i) begin
            byte_cnt <= byte_cnt + 1'b1;
          end else if (byte_cnt != '0) begin
            state     <= WAIT_CREDIT;
            done_pend <= 1'b1;
          end
        end
        default: begin
          state <= WAIT_CREDIT;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // byte packing into buffer words
  // ------------------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (take_byte) begin
      wr.addr <= buf_addr_t'(`RXCAP_BUF_BASE) + buf_addr_t'(byte_cnt >> 1);
      if (byte_cnt[0]) begin
        wr.data    <= {rx_data_i, 8'h00};
        wr.byte_en <= 2'b10;
      end else begin
        wr.data    <= {8'h00, rx_data_i};
        wr.byte_en <= 2'b01;
      end
      // first byte stamps the frame
      if (byte_cnt == '0) begin
        ts_cap <= global_count_i;
      end
    end
  end

endmodule

// ==== src/frame_wr_if.sv ====
`timescale 1ns/1ps

interface frame_wr_if
  import rxcap_bus_pkg::*, rxcap_frame_pkg::*;
();

  // one word write per cycle, no back-pressure
  logic      wr_en;
  buf_addr_t addr;
  bus_data_t data;
  bus_sel_t  byte_en;

  modport source (
    output wr_en, addr, data, byte_en
  );

  modport sink (
    input wr_en, addr, data, byte_en
  );

endinterface

// ==== src/rxcap_frame_pkg.sv ====
`include "rxcap_defs.svh"

package rxcap_frame_pkg;

  typedef logic [7:0] frame_byte_t;

  typedef logic [`RXCAP_BUF_AW-1:0] buf_addr_t;

  // byte count of one frame
  typedef logic [`RXCAP_LEN_W-1:0] frame_len_t;

  typedef logic [`RXCAP_TS_W-1:0] timestamp_t;

  // receiver FSM
  typedef enum logic [1:0] {
    WAIT_CREDIT,
    WAIT_GAP,
    CAPTURE
  } rx_state_e;

endpackage

// ==== src/rxcap_bus_pkg.sv ====
`include "rxcap_defs.svh"

package rxcap_bus_pkg;

  // byte address as seen by the host
  typedef logic [`RXCAP_ADR_W-1:0] bus_addr_t;

  typedef logic [`RXCAP_DATA_W-1:0] bus_data_t;

  // bit 1 selects bits 15..8
  typedef logic [`RXCAP_DATA_W/8-1:0] bus_sel_t;

endpackage

// ==== src/rxcap_defs.svh ====
`ifndef RXCAP_DEFS_SVH
`define RXCAP_DEFS_SVH

// ------------------------------------------------------------
// widths
// ------------------------------------------------------------

// host bus and buffer word
`define RXCAP_DATA_W 16
// host byte address
`define RXCAP_ADR_W 16
// buffer word address, 4096 words
`define RXCAP_BUF_AW 12
`define RXCAP_LEN_W 12
// global counter and timestamp
`define RXCAP_TS_W 64

// ------------------------------------------------------------
// register map
// ------------------------------------------------------------

// region codes live in address bits 15..13
`define RXCAP_REGION_GLOBAL 0
`define RXCAP_REGION_RX 4

// first buffer word, rx words below this are registers
`define RXCAP_BUF_BASE 8

// ack delay of a buffer read, in cycles
`define RXCAP_BUF_RD_LAT 3

`endif
